// ==== rtl/snowball_defs.svh ====
/* snowball shared sizes
   cache geometry and physical region codes */
`ifndef SNOWBALL_DEFS_SVH
`define SNOWBALL_DEFS_SVH

// ------------------------------
// cache and table geometry
// ------------------------------
`define SNOWBALL_INDEX_BITS 8      // 256 lines, 256 table entries
`define SNOWBALL_TAG_BITS   24     // physical addr 31:8

// ------------------------------
// physical regions in addr 31:30
// ------------------------------
`define SNOWBALL_REGION_MEM 2'b00  // memory bus
`define SNOWBALL_REGION_DMA 2'b11  // dma bus

`endif

// ==== rtl/snowball_pkg.sv ====
/* snowball shared types
   FSM state encodings and the decoded bus region */
package snowball_pkg;

  // lookup front end
  typedef enum logic [1:0] {
    LKP_IDLE,      // line clear after reset, else waiting for a strobe
    LKP_CHECK,     // ram outputs valid, decide hit/fault/bus
    LKP_WAIT_BUS   // transaction open, busy high
  } lookup_state_t;

  // bus sequencer
  typedef enum logic [1:0] {
    BUS_IDLE,      // waiting for req
    BUS_MEM,       // mem_do_act held
    BUS_DMA,       // dma_read or dma_wrte held
    BUS_DONE       // ack seen, done next edge
  } bus_state_t;

  // decoded from addr 31:30
  typedef enum logic [1:0] {
    REGION_MEM,
    REGION_DMA,
    REGION_NONE    // 01 and 10, nothing mapped
  } region_t;

endpackage

// ==== rtl/snowball_bus_if.sv ====
/* snowball bus handoff
   one single-word transaction at a time from lookup to sequencer */
`timescale 1ns/1ns

interface snowball_bus_if
  import snowball_pkg::*;
();

  logic        req;    // one-cycle start pulse
  logic        we;     // write flag
  logic [31:0] addr;   // physical address
  logic [31:0] wdata;
  logic        done;   // one-cycle completion pulse
  logic [31:0] rdata;  // zero for unmapped reads
  logic        fill;   // completion was in the memory region

  // lookup front end side
  modport lookup (
    output req, we, addr, wdata,
    input  done, rdata, fill
  );

  // sequencer side
  modport bus (
    input  req, we, addr, wdata,
    output done, rdata, fill
  );

endinterface

// ==== rtl/snowball_sram.sv ====
/* snowball sram
   one write port and one read port with registered read data */
`timescale 1ns/1ns

module snowball_sram #(
  parameter int WIDTH      = 32,
  parameter int DEPTH_BITS = 8
)
(
  input  logic                  CPU_CLK,
  input  logic                  we,
  input  logic [DEPTH_BITS-1:0] waddr,
  input  logic [WIDTH-1:0]      wdata,
  input  logic                  re,
  input  logic [DEPTH_BITS-1:0] raddr,
  output logic [WIDTH-1:0]      rdata
);

  logic [WIDTH-1:0] mem [2**DEPTH_BITS];

  always_ff @(posedge CPU_CLK)
  begin
    if (we)
      mem[waddr] <= wdata;
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (re)
      rdata <= mem[raddr];  // old data on same-address write
  end

endmodule

// ==== rtl/snowball_lookup.sv ====
/* snowball lookup front end
   translation check, tag compare, fault, cache fill and CPU data return */
`timescale 1ns/1ns
`include "snowball_defs.svh"

module snowball_lookup
  import snowball_pkg::*;
(
  input  logic          CPU_CLK,
  input  logic          RST,
  input  logic [31:0]   cache_precycle_addr,
  input  logic [31:0]   cache_datao,
  input  logic          cache_precycle_we,
  input  logic          cache_precycle_enable,
  input  logic          cache_precycle_force_miss,
  input  logic          cache_inhibit,
  input  logic          VMEM_ACT,
  input  logic          WE_TLB,
  output logic [31:0]   cache_datai,
  output logic          cache_busy,
  output logic          MMU_FAULT,
  snowball_bus_if.lookup bus
);

  localparam int IDX_W = `SNOWBALL_INDEX_BITS;
  localparam int TAG_W = `SNOWBALL_TAG_BITS;
  localparam int OFF_W = 2 * IDX_W;  // untranslated low half of the address

  lookup_state_t    state;
  logic             clearing;
  logic [IDX_W-1:0] clear_idx;

  logic [31:0] cyc_addr;
  logic [31:0] cyc_wdata;
  logic        cyc_we;
  logic        cyc_force;
  logic        cyc_inhibit;
  logic        cyc_vmem;

  logic [31:0]       data_rd;
  logic [TAG_W:0]    tag_rd;     // {valid, tag}
  logic [31:0]       tlb_rd;     // {physical page, virtual tag}
  logic [31-OFF_W:0] phys_page;
  logic [OFF_W-1:0]  entry_vtag;
  logic [31:0]       paddr;
  logic [TAG_W-1:0]  ptag;

  logic             start;
  logic             chk_fault;
  logic             chk_hit;
  logic             chk_bus;
  logic             bus_ret;
  logic             tlb_we;
  logic             fill_we;
  logic [31:0]      fill_data;
  logic             tag_we;
  logic [IDX_W-1:0] tag_waddr;
  logic [TAG_W:0]   tag_wdata;

  // ------------------------------
  // translation and hit decision
  // ------------------------------
  assign phys_page  = tlb_rd[31:OFF_W];
  assign entry_vtag = tlb_rd[OFF_W-1:0];
  assign paddr      = cyc_vmem ? {phys_page, cyc_addr[OFF_W-1:0]} : cyc_addr;
  assign ptag       = paddr[31:IDX_W];

  assign chk_fault = cyc_vmem && (entry_vtag != cyc_addr[31:OFF_W]);
  assign chk_hit   = !chk_fault && tag_rd[TAG_W] && (tag_rd[TAG_W-1:0] == ptag) &&
                     !cyc_we && !cyc_force && !cyc_inhibit;
  assign chk_bus   = (state == LKP_CHECK) && !chk_fault && !chk_hit;

  // a strobe during CHECK is taken only when no transaction follows
  assign start   = cache_precycle_enable && !cache_busy && !chk_bus;
  assign bus_ret = (state == LKP_WAIT_BUS) && bus.done;
  assign tlb_we  = WE_TLB && !cache_busy;   // written straight from the cpu side

  assign fill_we   = bus_ret && bus.fill && !cyc_inhibit;
  assign fill_data = cyc_we ? cyc_wdata : bus.rdata;
  assign tag_we    = clearing || fill_we;
  assign tag_waddr = clearing ? clear_idx : bus.addr[IDX_W-1:0];
  assign tag_wdata = clearing ? '0 : {1'b1, bus.addr[31:IDX_W]};

  // ------------------------------
  // line and table storage
  // ------------------------------
  snowball_sram #(.WIDTH(32), .DEPTH_BITS(IDX_W)) u_data (
    .CPU_CLK (CPU_CLK),
    .we      (fill_we),
    .waddr   (bus.addr[IDX_W-1:0]),
    .wdata   (fill_data),
    .re      (start),
    .raddr   (cache_precycle_addr[IDX_W-1:0]),
    .rdata   (data_rd)
  );

  snowball_sram #(.WIDTH(TAG_W + 1), .DEPTH_BITS(IDX_W)) u_tag (
    .CPU_CLK (CPU_CLK),
    .we      (tag_we),
    .waddr   (tag_waddr),
    .wdata   (tag_wdata),
    .re      (start),
    .raddr   (cache_precycle_addr[IDX_W-1:0]),
    .rdata   (tag_rd)
  );

  snowball_sram #(.WIDTH(32), .DEPTH_BITS(IDX_W)) u_tlb (
    .CPU_CLK (CPU_CLK),
    .we      (tlb_we),
    .waddr   (cache_precycle_addr[OFF_W-1:IDX_W]),
    .wdata   (cache_datao),  // {page, vtag}
    .re      (start),
    .raddr   (cache_precycle_addr[OFF_W-1:IDX_W]),
    .rdata   (tlb_rd)
  );

  // ------------------------------
  // control FSM
  // ------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      state      <= LKP_IDLE;
      clearing   <= 1'b1;
      clear_idx  <= '0;
      cache_busy <= 1'b1;   // held through the valid-bit walk
      MMU_FAULT  <= 1'b0;
      bus.req    <= 1'b0;
    end
    else
    begin
      bus.req   <= 1'b0;
      MMU_FAULT <= 1'b0;
      case (state)
        LKP_IDLE:
        begin
          if (clearing)
          begin
            clear_idx <= clear_idx + IDX_W'(1);
            if (&clear_idx)
            begin
              clearing   <= 1'b0;
              cache_busy <= 1'b0;
            end
          end
          else if (start)
            state <= LKP_CHECK;
        end
        LKP_CHECK:
        begin
          if (chk_fault || chk_hit)
          begin
            MMU_FAULT <= chk_fault;  // one cycle only
            state     <= start ? LKP_CHECK : LKP_IDLE;
          end
          else
          begin
            bus.req    <= 1'b1;
            cache_busy <= 1'b1;
            state      <= LKP_WAIT_BUS;
          end
        end
        LKP_WAIT_BUS:
        begin
          if (bus.done)
          begin
            cache_busy <= 1'b0;
            state      <= LKP_IDLE;
          end
        end
        default: state <= LKP_IDLE;
      endcase
    end
  end

  // cycle registers and returned data
  always_ff @(posedge CPU_CLK)
  begin
    if (start)
    begin
      cyc_addr    <= cache_precycle_addr;
      cyc_wdata   <= cache_datao;
      cyc_we      <= cache_precycle_we;
      cyc_force   <= cache_precycle_force_miss;
      cyc_inhibit <= cache_inhibit;
      cyc_vmem    <= VMEM_ACT;
    end
    if (chk_bus)
    begin
      bus.addr  <= paddr;
      bus.we    <= cyc_we;
      bus.wdata <= cyc_wdata;
    end
    if ((state == LKP_CHECK) && chk_hit)
      cache_datai <= data_rd;
    else if (bus_ret && !cyc_we)
      cache_datai <= bus.rdata;
  end

endmodule

// ==== rtl/snowball_bus_ctrl.sv ====
/* snowball bus sequencer
   region decode and single-word strobes on the memory and DMA buses */
`timescale 1ns/1ns
`include "snowball_defs.svh"

module snowball_bus_ctrl
  import snowball_pkg::*;
(
  input  logic        CPU_CLK,
  input  logic        RST,
  input  logic        mem_ack,
  input  logic [31:0] mem_datafrommem,
  input  logic        dma_wrte_ack,
  input  logic        dma_read_ack,
  input  logic [31:0] dma_data_read,
  output logic [31:0] mem_addr,
  output logic        mem_we,
  output logic        mem_do_act,
  output logic [31:0] mem_dataintomem,
  output logic        dma_wrte,
  output logic        dma_read,
  snowball_bus_if.bus bus
);

  bus_state_t state;
  region_t    region;
  logic       accept;
  logic       mem_fin;
  logic       dma_fin;

  // ------------------------------
  // region decode
  // ------------------------------
  always_comb
  begin
    case (bus.addr[31:30])
      `SNOWBALL_REGION_MEM: region = REGION_MEM;
      `SNOWBALL_REGION_DMA: region = REGION_DMA;
      default:              region = REGION_NONE;
    endcase
  end

  assign accept  = (state == BUS_IDLE) && bus.req;
  assign mem_fin = (state == BUS_MEM) && mem_ack;
  assign dma_fin = (state == BUS_DMA) &&
                   ((dma_read && dma_read_ack) || (dma_wrte && dma_wrte_ack));

  // ------------------------------
  // sequencer
  // ------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      state      <= BUS_IDLE;
      mem_do_act <= 1'b0;
      mem_we     <= 1'b0;
      dma_read   <= 1'b0;
      dma_wrte   <= 1'b0;
      bus.done   <= 1'b0;
    end
    else
    begin
      bus.done <= 1'b0;
      case (state)
        BUS_IDLE:
        begin
          if (bus.req)
          begin
            case (region)
              REGION_MEM:
              begin
                mem_do_act <= 1'b1;
                mem_we     <= bus.we;
                state      <= BUS_MEM;
              end
              REGION_DMA:
              begin
                dma_read <= !bus.we;
                dma_wrte <= bus.we;
                state    <= BUS_DMA;
              end
              default: bus.done <= 1'b1;  // unmapped, finish at once
            endcase
          end
        end
        BUS_MEM:
        begin
          if (mem_fin)
          begin
            mem_do_act <= 1'b0;
            mem_we     <= 1'b0;
            state      <= BUS_DONE;
          end
        end
        BUS_DMA:
        begin
          if (dma_fin)
          begin
            dma_read <= 1'b0;
            dma_wrte <= 1'b0;
            state    <= BUS_DONE;
          end
        end
        BUS_DONE:
        begin
          bus.done <= 1'b1;
          state    <= BUS_IDLE;
        end
        default: state <= BUS_IDLE;
      endcase
    end
  end

  // address, write data and read data capture
  always_ff @(posedge CPU_CLK)
  begin
    if (accept)
    begin
      mem_addr        <= bus.addr;   // shared by both buses
      mem_dataintomem <= bus.wdata;
      bus.fill        <= (region == REGION_MEM);
      bus.rdata       <= '0;         // stays zero when unmapped
    end
    if (mem_fin)
      bus.rdata <= mem_datafrommem;
    else if (dma_fin)
      bus.rdata <= dma_data_read;
  end

endmodule

// ==== rtl/snowball_cache.sv ====
/* snowball cache top
   lookup front end and bus sequencer joined by the bus handoff */
`timescale 1ns/1ns

module snowball_cache
  import snowball_pkg::*;
(
  input  logic        CPU_CLK,
  input  logic        RST,
  // cpu side
  input  logic [31:0] cache_precycle_addr,
  input  logic [31:0] cache_datao,
  output logic [31:0] cache_datai,
  input  logic        cache_precycle_we,
  input  logic        cache_precycle_enable,
  input  logic        cache_precycle_force_miss,
  input  logic        cache_inhibit,
  output logic        cache_busy,
  input  logic        VMEM_ACT,
  input  logic        WE_TLB,
  output logic        MMU_FAULT,
  // memory bus
  output logic [31:0] mem_addr,
  output logic        mem_we,
  output logic        mem_do_act,
  output logic [31:0] mem_dataintomem,
  input  logic        mem_ack,
  input  logic [31:0] mem_datafrommem,
  // dma bus
  output logic        dma_wrte,
  output logic        dma_read,
  input  logic        dma_wrte_ack,
  input  logic        dma_read_ack,
  input  logic [31:0] dma_data_read
);

  snowball_bus_if bus_if ();

  snowball_lookup u_lookup (
    .CPU_CLK                   (CPU_CLK),
    .RST                       (RST),
    .cache_precycle_addr       (cache_precycle_addr),
    .cache_datao               (cache_datao),
    .cache_precycle_we         (cache_precycle_we),
    .cache_precycle_enable     (cache_precycle_enable),
    .cache_precycle_force_miss (cache_precycle_force_miss),
    .cache_inhibit             (cache_inhibit),
    .VMEM_ACT                  (VMEM_ACT),
    .WE_TLB                    (WE_TLB),
    .cache_datai               (cache_datai),
    .cache_busy                (cache_busy),
    .MMU_FAULT                 (MMU_FAULT),
    .bus                       (bus_if.lookup)
  );

  snowball_bus_ctrl u_bus (
    .CPU_CLK         (CPU_CLK),
    .RST             (RST),
    .mem_ack         (mem_ack),
    .mem_datafrommem (mem_datafrommem),
    .dma_wrte_ack    (dma_wrte_ack),
    .dma_read_ack    (dma_read_ack),
    .dma_data_read   (dma_data_read),
    .mem_addr        (mem_addr),
    .mem_we          (mem_we),
    .mem_do_act      (mem_do_act),
    .mem_dataintomem (mem_dataintomem),
    .dma_wrte        (dma_wrte),
    .dma_read        (dma_read),
    .bus             (bus_if.bus)
  );

endmodule

// ==== dv/snowball_tb.sv ====
/* snowball cache testbench
   plays access vectors against memory and DMA bus models */
`timescale 1ns/1ns

module snowball_tb;

  localparam int         MAX_VECTORS = 64;
  localparam logic [3:0] OP_READ     = 4'd1;
  localparam logic [3:0] OP_WRITE    = 4'd2;
  localparam logic [3:0] OP_TABLE    = 4'd3;
  localparam logic [3:0] OP_FORCE    = 4'd4;
  localparam logic [3:0] OP_INHIB    = 4'd5;

  logic        CPU_CLK = 1'b0;
  logic        RST;
  logic [31:0] cache_precycle_addr;
  logic [31:0] cache_datao;
  logic [31:0] cache_datai;
  logic        cache_precycle_we;
  logic        cache_precycle_enable;
  logic        cache_precycle_force_miss;
  logic        cache_inhibit;
  logic        cache_busy;
  logic        VMEM_ACT;
  logic        WE_TLB;
  logic        MMU_FAULT;
  logic [31:0] mem_addr;
  logic        mem_we;
  logic        mem_do_act;
  logic [31:0] mem_dataintomem;
  logic        mem_ack         = 1'b0;
  logic [31:0] mem_datafrommem = '0;
  logic        dma_wrte;
  logic        dma_read;
  logic        dma_wrte_ack    = 1'b0;
  logic        dma_read_ack    = 1'b0;
  logic [31:0] dma_data_read   = '0;

  logic [111:0] vectors [MAX_VECTORS];  // op vmem fault bus addr wdata expect
  int           num_vectors;
  int           limit_cycles;
  logic [15:0]  tlb_page [256];         // reference copy of table pages
  logic [31:0]  exp_addr  = '0;
  logic         exp_we    = 1'b0;
  logic [31:0]  exp_wdata = '0;
  logic [31:0]  store_addr [$];         // words written on the memory bus
  logic [31:0]  store_data [$];
  logic [31:0]  lfsr      = 32'h5a0030bf;
  logic         mem_open  = 1'b0;
  logic         dma_open  = 1'b0;
  int           mem_wait  = 0;
  int           dma_wait  = 0;
  int           mem_rises = 0;
  int           dma_rises = 0;
  int           data_errors = 0;
  int           bus_errors  = 0;
  int           flag_errors = 0;

  snowball_cache u_dut (.*);

  always #50 CPU_CLK = ~CPU_CLK;

  // ------------------------------
  // helpers
  // ------------------------------
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'h80200003;  // taps 32 22 2 1
    return s >> 1;
  endfunction

  task automatic draw_wait(output int cycles);
    cycles = 0;
    for (int b = 0; b < 2; b++)
    begin
      lfsr   = lfsr_step(lfsr);
      cycles = cycles * 2 + (lfsr[0] ? 1 : 0);  // one step per bit
    end
  endtask

  function automatic int find_word(input logic [31:0] a);
    for (int k = 0; k < store_addr.size(); k++)
    begin
      if (store_addr[k] == a)
        return k;
    end
    return -1;
  endfunction

  function automatic logic [31:0] mem_word(input logic [31:0] a);
    int k;
    k = find_word(a);
    if (k >= 0)
      return store_data[k];
    return a ^ 32'hc0de0000;  // never written
  endfunction

  task automatic store_word(input logic [31:0] a, input logic [31:0] d);
    int k;
    k = find_word(a);
    if (k >= 0)
      store_data[k] = d;
    else
    begin
      store_addr.push_back(a);
      store_data.push_back(d);
    end
  endtask

  // address, direction and write data at the strobe rise
  task automatic check_request(input logic we_seen, input string we_name);
    if (mem_addr != exp_addr)
    begin
      $display("error: mem_addr expected %h got %h", exp_addr, mem_addr);
      bus_errors++;
    end
    if (we_seen != exp_we)
    begin
      $display("error: %s expected %h got %h", we_name, exp_we, we_seen);
      bus_errors++;
    end
    if (exp_we && (mem_dataintomem != exp_wdata))
    begin
      $display("error: mem_dataintomem expected %h got %h", exp_wdata, mem_dataintomem);
      bus_errors++;
    end
  endtask

  // ------------------------------
  // bus models
  // ------------------------------
  always @(posedge mem_do_act)
    mem_rises = mem_rises + 1;

  always @(posedge dma_read or posedge dma_wrte)
    dma_rises = dma_rises + 1;

  always @(posedge CPU_CLK)
  begin
    #5;
    if (!mem_do_act)
    begin
      mem_ack  = 1'b0;
      mem_open = 1'b0;
    end
    else
    begin
      if (!mem_open)
      begin
        mem_open = 1'b1;
        draw_wait(mem_wait);
        check_request(mem_we, "mem_we");
        if (mem_we)
          store_word(mem_addr, mem_dataintomem);
      end
      if (mem_wait == 0)
      begin
        mem_ack = 1'b1;
        if (mem_we)
          mem_datafrommem = ~mem_dataintomem;  // junk on the data bus for writes
        else
          mem_datafrommem = mem_word(mem_addr);
      end
      else
        mem_wait = mem_wait - 1;  // back-pressure
    end
    if (!(dma_read || dma_wrte))
    begin
      dma_read_ack = 1'b0;
      dma_wrte_ack = 1'b0;
      dma_open     = 1'b0;
    end
    else
    begin
      if (!dma_open)
      begin
        dma_open = 1'b1;
        draw_wait(dma_wait);
        check_request(dma_wrte, "dma_wrte");
      end
      if (dma_wait == 0)
      begin
        dma_read_ack  = dma_read;
        dma_wrte_ack  = dma_wrte;
        dma_data_read = ~mem_addr;
      end
      else
        dma_wait = dma_wait - 1;
    end
  end

  // ------------------------------
  // vector player
  // ------------------------------
  task automatic run_vector(input int idx);
    logic [3:0]  op;
    logic        vmem;
    logic        fault;
    logic [3:0]  bus;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] expect_data;
    logic        expect_hit;
    int          mem_before;
    int          dma_before;
    op          = vectors[idx][111:108];
    vmem        = vectors[idx][104];
    fault       = vectors[idx][100];
    bus         = vectors[idx][99:96];
    addr        = vectors[idx][95:64];
    wdata       = vectors[idx][63:32];
    expect_data = vectors[idx][31:0];
    mem_before  = mem_rises;
    dma_before  = dma_rises;
    exp_addr    = vmem ? {tlb_page[addr[15:8]], addr[15:0]} : addr;
    exp_we      = (op == OP_WRITE);
    exp_wdata   = wdata;
    expect_hit  = (op == OP_READ) && (bus == 4'd0) && !fault && (exp_addr[31:30] == 2'b00);

    cache_precycle_addr = addr;
    cache_datao         = wdata;
    if (op == OP_TABLE)
    begin
      WE_TLB               = 1'b1;
      tlb_page[addr[15:8]] = wdata[31:16];  // entry is {page, vtag}
    end
    else
    begin
      cache_precycle_enable     = 1'b1;
      cache_precycle_we         = (op == OP_WRITE);
      cache_precycle_force_miss = (op == OP_FORCE);
      cache_inhibit             = (op == OP_INHIB);
      VMEM_ACT                  = vmem;
    end
    @(posedge CPU_CLK);  // E0
    #5;
    WE_TLB                    = 1'b0;
    cache_precycle_enable     = 1'b0;
    cache_precycle_we         = 1'b0;
    cache_precycle_force_miss = 1'b0;
    cache_inhibit             = 1'b0;
    VMEM_ACT                  = 1'b0;

    if (op == OP_TABLE)
    begin
      if (cache_busy)
      begin
        $display("vector %0d: cache_busy rose on a table write", idx);
        flag_errors++;
      end
    end
    else
    begin
      @(posedge CPU_CLK);  // E1 hit or fault decided
      #5;
      if (MMU_FAULT != fault)
      begin
        $display("error: MMU_FAULT expected %h got %h (vector %0d)", fault, MMU_FAULT, idx);
        flag_errors++;
      end
      if (cache_busy && (expect_hit || fault))
      begin
        $display("vector %0d: cache_busy rose on an access that should stay local", idx);
        flag_errors++;
      end
      while (cache_busy)
      begin
        @(posedge CPU_CLK);
        #5;
      end
      if ((op != OP_WRITE) && !fault && (cache_datai != expect_data))
      begin
        $display("error: cache_datai expected %h got %h (vector %0d)",
                 expect_data, cache_datai, idx);
        data_errors++;
      end
    end

    @(posedge CPU_CLK);  // late strobes would show here
    #5;
    if (MMU_FAULT)
    begin
      $display("vector %0d: MMU_FAULT stayed high past one cycle", idx);
      flag_errors++;
    end
    if ((mem_rises - mem_before) != ((bus == 4'd1) ? 1 : 0))
    begin
      $display("vector %0d: wrong number of memory bus accesses, saw %0d",
               idx, mem_rises - mem_before);
      bus_errors++;
    end
    if ((dma_rises - dma_before) != ((bus == 4'd2) ? 1 : 0))
    begin
      $display("vector %0d: wrong number of DMA bus accesses, saw %0d",
               idx, dma_rises - dma_before);
      bus_errors++;
    end
  endtask

  // ------------------------------
  // main sequence and watchdog
  // ------------------------------
  initial
  begin
    RST                       = 1'b0;
    cache_precycle_addr       = '0;
    cache_datao               = '0;
    cache_precycle_we         = 1'b0;
    cache_precycle_enable     = 1'b0;
    cache_precycle_force_miss = 1'b0;
    cache_inhibit             = 1'b0;
    VMEM_ACT                  = 1'b0;
    WE_TLB                    = 1'b0;
    for (int k = 0; k < MAX_VECTORS; k++)
      vectors[k] = '0;  // opcode 0 ends the list
    $readmemh("dv/snowball_vectors.txt", vectors);
    num_vectors = 0;
    while ((num_vectors < MAX_VECTORS) && (vectors[num_vectors][111:108] != 4'd0))
      num_vectors++;
    if (num_vectors == 0)
    begin
      $display("no access vectors were read");
      flag_errors++;
    end

    repeat (4) @(posedge CPU_CLK);
    #5;
    RST = 1'b1;
    if (MMU_FAULT || mem_do_act || mem_we || dma_read || dma_wrte)
    begin
      $display("fault flag or bus strobe high after reset");
      flag_errors++;
    end
    while (cache_busy)  // valid-bit walk
    begin
      @(posedge CPU_CLK);
      #5;
    end
    if (cache_busy !== 1'b0)
    begin
      $display("cache_busy is not low after the valid-bit walk");
      flag_errors++;
    end

    for (int k = 0; k < num_vectors; k++)
      run_vector(k);

    $display("errors: data %0d, bus %0d, flags %0d", data_errors, bus_errors, flag_errors);
    if ((data_errors + bus_errors + flag_errors) == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

  initial
  begin
    #1;
    limit_cycles = num_vectors * 40 + 400;
    repeat (limit_cycles) @(posedge CPU_CLK);
    $display("timeout: run did not finish within %0d clock cycles", limit_cycles);
    $display("Test failed");
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+rtl
rtl/snowball_pkg.sv
rtl/snowball_bus_if.sv
rtl/snowball_sram.sv
rtl/snowball_lookup.sv
rtl/snowball_bus_ctrl.sv
rtl/snowball_cache.sv
dv/snowball_tb.sv

// ==== Makefile ====
# Verilator build and run for the snowball cache
SIM      = verilator
VFLAGS   = --binary --timing -j 0
TOP      = snowball_tb
FILELIST = all.f
PASS_MSG = Test completed successfully

BUILD   = obj_dir
BIN     = $(BUILD)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST)) $(wildcard rtl/*.svh)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)

// ==== dv/snowball_vectors.txt ====
// op_vmem_fault_bus_addr_wdata_expect, one access per line
// op 1 read 2 write 3 table write 4 forced read 5 inhibited read; bus 0 none 1 mem 2 dma
// memory region, hits, write-through, forced and inhibited reads
1_0_0_1_00000010_00000000_c0de0010
1_0_0_0_00000010_00000000_c0de0010
2_0_0_1_00000014_a5a50014_00000000
1_0_0_0_00000014_00000000_a5a50014
4_0_0_1_00000014_00000000_a5a50014
5_0_0_1_00000018_00000000_c0de0018
1_0_0_1_00000018_00000000_c0de0018
1_0_0_0_00000018_00000000_c0de0018
1_0_0_1_00001010_00000000_c0de1010
1_0_0_1_00000010_00000000_c0de0010
5_0_0_1_00000010_00000000_c0de0010
1_0_0_0_00000010_00000000_c0de0010
2_0_0_1_00001010_deadbeef_00000000
1_0_0_0_00001010_00000000_deadbeef
1_0_0_1_00000010_00000000_c0de0010
// translation, entry 12 maps vtag 0040 to page 0003
3_0_0_0_00001200_00030040_00000000
1_1_0_1_00401234_00000000_c0dd1234
1_1_0_0_00401234_00000000_c0dd1234
1_0_0_0_00031234_00000000_c0dd1234
1_1_1_0_00411234_00000000_00000000
2_1_0_1_00401238_0badf00d_00000000
1_0_0_0_00031238_00000000_0badf00d
// DMA region, entry 20 maps vtag 0050 to page c001
3_0_0_0_00002000_c0010050_00000000
1_0_0_2_c0000020_00000000_3fffffdf
1_0_0_2_c0000020_00000000_3fffffdf
2_0_0_2_c0000024_12345678_00000000
1_1_0_2_00502088_00000000_3ffedf77
// unmapped regions
1_0_0_0_40000030_00000000_00000000
2_0_0_0_80000034_55555555_00000000
1_0_0_0_00000018_00000000_c0de0018
1_0_0_0_80000034_00000000_00000000
